// File: filelist.f
src/core_pkg.sv
src/inst_queue.sv
src/reg_file.sv
src/decode.sv
src/execute.sv
src/result.sv
src/core_top.sv
bench/core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f --top-module core_tb -o core_tb_sim

./obj_dir/core_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: bench/core_tb.sv
`timescale 1ns/10ps

module core_tb;

    localparam int NUM_INSTS      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTS * 10 + 200;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    core_pkg::inst_t      in_inst;
    core_pkg::pc_t        in_pc;
    logic                 in_credit;
    logic                 out_valid;
    core_pkg::kind_e      out_kind;
    core_pkg::reg_idx_t   out_rd;
    core_pkg::word_t      out_value;
    core_pkg::pc_t        out_pc;
    logic                 out_credit;

    core_pkg::inst_t      prog       [NUM_INSTS];
    core_pkg::pc_t        prog_pc    [NUM_INSTS];
    core_pkg::kind_e      exp_kind   [NUM_INSTS];
    core_pkg::reg_idx_t   exp_rd     [NUM_INSTS];
    core_pkg::word_t      exp_value  [NUM_INSTS];
    core_pkg::pc_t        exp_pc     [NUM_INSTS];
    core_pkg::word_t      model_regs [32];  // r0 is never written

    int  cycle;
    int  sent;           // instructions pushed into the DUT
    int  received;       // records checked so far
    int  send_credits;   // credits held by the sender
    int  credit_pulses;  // in_credit pulses seen
    int  cons_credits;   // credits the DUT holds for output records
    int  credit_due [$]; // cycles at which out_credit goes back
    int  last_due;
    int  ret_delay;      // cycles before a credit goes back

    core_top UUT (
        .clk, .reset, .in_valid, .in_inst, .in_pc, .in_credit,
        .out_valid, .out_kind, .out_rd, .out_value, .out_pc, .out_credit
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input core_pkg::word_t exp,
                              input core_pkg::word_t act);
        if (act !== exp)
            stop_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_idx(input string name, input core_pkg::reg_idx_t exp,
                             input core_pkg::reg_idx_t act);
        if (act !== exp)
            stop_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_pc(input string name, input core_pkg::pc_t exp,
                            input core_pkg::pc_t act);
        if (act !== exp)
            stop_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_kind(input string name, input core_pkg::kind_e exp,
                              input core_pkg::kind_e act);
        if (act !== exp)
            stop_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
    endtask

    function automatic core_pkg::word_t sext16(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic core_pkg::reg_idx_t pick_reg();
        return core_pkg::reg_idx_t'($urandom_range(7, 0));  // few registers give many hazards
    endfunction

    task automatic build_program();
        int unsigned      sel;
        logic [2:0]       funct;
        core_pkg::inst_t  inst;
        for (int i = 0; i < NUM_INSTS; i++) begin
            inst = $urandom;  // immediates and unused bits stay random
            sel  = $urandom_range(19, 0);
            if (sel < 17) begin
                inst[31:27] = pick_reg();
                inst[10:6]  = pick_reg();
            end
            if (sel < 15)
                inst[26:22] = pick_reg();  // branches keep the full offset
            if (sel < 7) begin
                inst[2:0] = core_pkg::OP_ALU;
            end else if (sel < 12) begin
                inst[2:0] = core_pkg::OP_ALUI;
            end else if (sel < 15) begin
                inst[2:0] = core_pkg::OP_UPPER;
                inst[5:3] = core_pkg::LUI_FUNCT;
            end else if (sel < 17) begin
                inst[2:0] = core_pkg::OP_BRANCH;
                inst[5:3] = 3'($urandom_range(5, 0));
            end else if (sel == 17) begin
                inst[2:0] = core_pkg::OP_JUMP;
            end else begin
                funct = 3'($urandom_range(6, 0));
                case ($urandom_range(3, 0))
                    0:       inst[2:0] = 3'b001;
                    1:       inst[2:0] = 3'b010;
                    2:       inst[2:0] = 3'b011;
                    default: begin
                        inst[2:0] = core_pkg::OP_UPPER;
                        inst[5:3] = (funct >= 3'd2) ? funct + 3'd1 : funct;  // skip lui
                    end
                endcase
            end
            prog[i]    = inst;
            prog_pc[i] = core_pkg::pc_t'(27'h0001000 + 4 * i);
        end
    endtask

    // reference ISA run in program order
    task automatic model_step(input int i);
        core_pkg::inst_t     inst;
        logic [2:0]          op;
        logic [2:0]          funct;
        core_pkg::reg_idx_t  rd;
        core_pkg::word_t     a;
        core_pkg::word_t     b;
        core_pkg::word_t     v;
        logic                taken;
        inst  = prog[i];
        op    = inst[2:0];
        funct = inst[5:3];
        rd    = inst[26:22];
        a     = model_regs[inst[31:27]];
        b     = (op == core_pkg::OP_ALUI) ? sext16(inst[21:6]) : model_regs[inst[10:6]];
        exp_rd[i]    = rd;
        exp_pc[i]    = prog_pc[i];
        exp_value[i] = '0;
        exp_kind[i]  = core_pkg::KIND_ILLEGAL;
        v            = '0;
        case (op)
            core_pkg::OP_ALU, core_pkg::OP_ALUI: begin
                case (funct)
                    core_pkg::ADD: v = a + b;
                    core_pkg::SUB: v = a - b;
                    core_pkg::AND: v = a & b;
                    core_pkg::OR:  v = a | b;
                    core_pkg::XOR: v = a ^ b;
                    core_pkg::SLL: v = a << b[4:0];
                    core_pkg::SRL: v = a >> b[4:0];
                    default:       v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                endcase
                exp_kind[i] = core_pkg::KIND_WB;
            end
            core_pkg::OP_UPPER: begin
                if (funct == core_pkg::LUI_FUNCT) begin
                    v           = {inst[21:6], 16'h0000};
                    exp_kind[i] = core_pkg::KIND_WB;
                end
            end
            core_pkg::OP_BRANCH: begin
                case (funct)
                    core_pkg::EQ:  taken = (a == b);
                    core_pkg::NE:  taken = (a != b);
                    core_pkg::LT:  taken = ($signed(a) < $signed(b));
                    core_pkg::GE:  taken = ($signed(a) >= $signed(b));
                    core_pkg::LTU: taken = (a < b);
                    default:       taken = (a >= b);  // geu
                endcase
                exp_kind[i]  = core_pkg::KIND_BRANCH;
                exp_value[i] = {31'b0, taken};
                exp_pc[i]    = prog_pc[i] + core_pkg::pc_t'(sext16(inst[26:11]) << 2);
            end
            core_pkg::OP_JUMP: begin
                exp_kind[i] = core_pkg::KIND_JUMP;
                exp_pc[i]   = {inst[30:6], 2'b00};
            end
            default: ;  // illegal leaves the registers alone
        endcase
        if (exp_kind[i] == core_pkg::KIND_WB) begin
            exp_value[i] = v;
            if (rd != '0)
                model_regs[rd] = v;
        end
    endtask

    task automatic check_record(input int idx);
        check_kind($sformatf("out_kind (record %0d)", idx), exp_kind[idx], out_kind);
        check_pc($sformatf("out_pc (record %0d)", idx), exp_pc[idx], out_pc);
        if (exp_kind[idx] == core_pkg::KIND_WB) begin
            check_idx($sformatf("out_rd (record %0d)", idx), exp_rd[idx], out_rd);
            check_word($sformatf("out_value (record %0d)", idx), exp_value[idx], out_value);
        end else if (exp_kind[idx] == core_pkg::KIND_BRANCH) begin
            check_word($sformatf("out_value (record %0d)", idx), exp_value[idx], out_value);
        end
    endtask

    // sender, consumer credit return and timeout
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle > TIMEOUT_CYCLES) begin
            stop_run($sformatf("Timeout after %0d cycles with %0d of %0d records received",
                               cycle, received, NUM_INSTS));
        end else if (!reset) begin
            if (sent < NUM_INSTS && send_credits > 0 && $urandom_range(9, 0) < 7) begin
                in_valid     <= 1'b1;
                in_inst      <= prog[sent];
                in_pc        <= prog_pc[sent];
                send_credits = send_credits - 1;
                sent         = sent + 1;
            end else begin
                in_valid <= 1'b0;  // random gap or no credit
            end
            if (credit_due.size() > 0 && credit_due[0] <= cycle) begin
                out_credit <= 1'b1;
                void'(credit_due.pop_front());
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    // outputs are sampled mid cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (out_valid) begin
                if (received >= NUM_INSTS) begin
                    stop_run("Error: a record arrived after the whole program was done");
                end else if (cons_credits == 0) begin
                    stop_run("Error: out_valid was sent while the DUT held no output credit");
                end else begin
                    check_record(received);
                    received     = received + 1;
                    cons_credits = cons_credits - 1;
                    ret_delay    = int'($urandom_range(5, 0));
                    last_due     = (cycle + ret_delay > last_due) ?
                                   cycle + ret_delay : last_due + 1;
                    credit_due.push_back(last_due);
                end
            end
            if (out_credit)
                cons_credits = cons_credits + 1;  // counted by the DUT at the next edge
            if (in_credit) begin
                credit_pulses = credit_pulses + 1;
                send_credits  = send_credits + 1;
                if (credit_pulses > sent)
                    stop_run("Error: more input credits came back than instructions were sent");
                else if (send_credits > core_pkg::QUEUE_DEPTH)
                    stop_run("Error: sender credits grew beyond the queue depth");
            end
        end
    end

    initial begin
        void'($urandom(32'h5434));
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_inst       = '0;
        in_pc         = '0;
        out_credit    = 1'b0;
        cycle         = 0;
        sent          = 0;
        received      = 0;
        send_credits  = core_pkg::QUEUE_DEPTH;
        credit_pulses = 0;
        cons_credits  = core_pkg::OUT_CREDITS;
        last_due      = 0;
        ret_delay     = 0;
        for (int r = 0; r < 32; r++)
            model_regs[r] = '0;
        build_program();
        for (int i = 0; i < NUM_INSTS; i++)
            model_step(i);
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        while (received < NUM_INSTS)
            @(posedge clk);
        repeat (20) @(posedge clk);  // room for a stray record and late credits
        if (sent != NUM_INSTS || credit_pulses != NUM_INSTS ||
            cons_credits != core_pkg::OUT_CREDITS) begin
            stop_run($sformatf("Error: run ended with %0d sent, %0d credits back, %0d held",
                               sent, credit_pulses, cons_credits));
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// File: src/core_top.sv
`timescale 1ns/10ps

module core_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid,
    input  core_pkg::inst_t      in_inst,
    input  core_pkg::pc_t        in_pc,
    output logic                 in_credit,
    output logic                 out_valid,
    output core_pkg::kind_e      out_kind,
    output core_pkg::reg_idx_t   out_rd,
    output core_pkg::word_t      out_value,
    output core_pkg::pc_t        out_pc,
    input  logic                 out_credit
);

    logic                 advance;
    logic                 pop;
    logic                 q_valid;
    core_pkg::inst_t      q_inst;
    core_pkg::pc_t        q_pc;

    core_pkg::reg_idx_t   rs1;
    core_pkg::reg_idx_t   rs2;
    core_pkg::word_t      rd1;
    core_pkg::word_t      rd2;

    logic                 dec_valid;
    core_pkg::op_e        dec_op;
    logic [2:0]           dec_funct;
    core_pkg::word_t      dec_a;
    core_pkg::word_t      dec_b;
    core_pkg::word_t      dec_imm;
    core_pkg::reg_idx_t   dec_rd;
    logic                 dec_wen;
    core_pkg::pc_t        dec_pc;
    core_pkg::pc_t        dec_jaddr;

    logic                 ex_wen;
    core_pkg::reg_idx_t   ex_rd;
    core_pkg::word_t      ex_value;
    logic                 exr_valid;
    core_pkg::kind_e      exr_kind;
    core_pkg::reg_idx_t   exr_rd;
    core_pkg::word_t      exr_value;
    core_pkg::pc_t        exr_pc;
    logic                 exr_wen;

    logic                 res_wen;
    core_pkg::reg_idx_t   res_rd;
    core_pkg::word_t      res_value;

    inst_queue u_queue (
        .clk, .reset, .in_valid, .in_inst, .in_pc, .pop,
        .in_credit, .q_valid, .q_inst, .q_pc
    );

    decode u_decode (
        .clk, .reset, .advance, .q_valid, .q_inst, .q_pc, .rd1, .rd2,
        .ex_wen, .ex_rd, .ex_value, .res_wen, .res_rd, .res_value,
        .pop, .rs1, .rs2, .dec_valid, .dec_op, .dec_funct, .dec_a, .dec_b,
        .dec_imm, .dec_rd, .dec_wen, .dec_pc, .dec_jaddr
    );

    // write port fed by the committing record
    reg_file u_regs (
        .clk, .reset, .rs1, .rs2,
        .wen(res_wen), .wd_idx(res_rd), .wd(res_value),
        .rd1, .rd2
    );

    execute u_execute (
        .clk, .reset, .advance, .dec_valid, .dec_op, .dec_funct, .dec_a, .dec_b,
        .dec_imm, .dec_rd, .dec_wen, .dec_pc, .dec_jaddr,
        .ex_wen, .ex_rd, .ex_value,
        .exr_valid, .exr_kind, .exr_rd, .exr_value, .exr_pc, .exr_wen
    );

    result u_result (
        .clk, .reset, .exr_valid, .exr_kind, .exr_rd, .exr_value, .exr_pc, .exr_wen,
        .out_credit, .advance, .res_wen, .res_rd, .res_value,
        .out_valid, .out_kind, .out_rd, .out_value, .out_pc
    );

endmodule

// File: src/result.sv
`timescale 1ns/10ps

module result (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 exr_valid,
    input  core_pkg::kind_e      exr_kind,
    input  core_pkg::reg_idx_t   exr_rd,
    input  core_pkg::word_t      exr_value,
    input  core_pkg::pc_t        exr_pc,
    input  logic                 exr_wen,
    input  logic                 out_credit,
    output logic                 advance,
    output logic                 res_wen,
    output core_pkg::reg_idx_t   res_rd,
    output core_pkg::word_t      res_value,
    output logic                 out_valid,
    output core_pkg::kind_e      out_kind,
    output core_pkg::reg_idx_t   out_rd,
    output core_pkg::word_t      out_value,
    output core_pkg::pc_t        out_pc
);

    logic [core_pkg::OUT_CNT_W-1:0] out_cnt;  // credits left at the consumer
    logic                           have_credit;

    assign have_credit = (out_cnt != '0);

    // whole pipe moves unless a record waits for a credit
    assign advance = have_credit || !exr_valid;

    assign out_valid = exr_valid && have_credit;  // held record is sent once
    assign out_kind  = exr_kind;
    assign out_rd    = exr_rd;
    assign out_value = exr_value;
    assign out_pc    = exr_pc;

    // commit of the held record and second forwarding source
    assign res_wen   = out_valid && exr_wen;
    assign res_rd    = exr_rd;
    assign res_value = exr_value;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_cnt <= core_pkg::OUT_CNT_W'(core_pkg::OUT_CREDITS);
        end else begin
            case ({out_credit, out_valid})
                2'b10:   out_cnt <= out_cnt + 1'b1;
                2'b01:   out_cnt <= out_cnt - 1'b1;
                default: out_cnt <= out_cnt;  // none or one in and one out
            endcase
        end
    end

    // consumer returns no more credits than were taken
    a_cnt_bound: assert property (@(posedge clk) disable iff (reset)
        out_cnt <= core_pkg::OUT_CREDITS);

    // last credit spent with none returned, nothing leaves next cycle
    a_send_credit: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_credit && out_cnt == 1) |=> !out_valid);

endmodule

// File: src/execute.sv
`timescale 1ns/10ps

module execute (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 advance,
    input  logic                 dec_valid,
    input  core_pkg::op_e        dec_op,
    input  logic [2:0]           dec_funct,
    input  core_pkg::word_t      dec_a,
    input  core_pkg::word_t      dec_b,
    input  core_pkg::word_t      dec_imm,
    input  core_pkg::reg_idx_t   dec_rd,
    input  logic                 dec_wen,
    input  core_pkg::pc_t        dec_pc,
    input  core_pkg::pc_t        dec_jaddr,
    output logic                 ex_wen,
    output core_pkg::reg_idx_t   ex_rd,
    output core_pkg::word_t      ex_value,
    output logic                 exr_valid,
    output core_pkg::kind_e      exr_kind,
    output core_pkg::reg_idx_t   exr_rd,
    output core_pkg::word_t      exr_value,
    output core_pkg::pc_t        exr_pc,
    output logic                 exr_wen
);

    core_pkg::word_t  alu_out;
    logic             taken;
    core_pkg::pc_t    br_target;
    core_pkg::kind_e  kind;
    core_pkg::pc_t    out_pc;

    always_comb begin
        case (core_pkg::alu_fn_e'(dec_funct))
            core_pkg::ADD: alu_out = dec_a + dec_b;
            core_pkg::SUB: alu_out = dec_a - dec_b;
            core_pkg::AND: alu_out = dec_a & dec_b;
            core_pkg::OR:  alu_out = dec_a | dec_b;
            core_pkg::XOR: alu_out = dec_a ^ dec_b;
            core_pkg::SLL: alu_out = dec_a << dec_b[4:0];
            core_pkg::SRL: alu_out = dec_a >> dec_b[4:0];
            default:       alu_out = {31'b0, $signed(dec_a) < $signed(dec_b)};  // slt
        endcase
    end

    always_comb begin
        case (core_pkg::br_fn_e'(dec_funct))
            core_pkg::EQ:  taken = (dec_a == dec_b);
            core_pkg::NE:  taken = (dec_a != dec_b);
            core_pkg::LT:  taken = ($signed(dec_a) < $signed(dec_b));
            core_pkg::GE:  taken = ($signed(dec_a) >= $signed(dec_b));
            core_pkg::LTU: taken = (dec_a < dec_b);
            core_pkg::GEU: taken = (dec_a >= dec_b);
            default:       taken = 1'b0;  // funct 6 and 7 never branch
        endcase
    end

    assign br_target = dec_pc + {dec_imm[24:0], 2'b00};  // wraps at 27 bits

    always_comb begin
        kind     = core_pkg::KIND_ILLEGAL;
        ex_value = '0;
        out_pc   = dec_pc;
        case (dec_op)
            core_pkg::OP_ALU,
            core_pkg::OP_ALUI: begin
                kind     = core_pkg::KIND_WB;
                ex_value = alu_out;
            end
            core_pkg::OP_UPPER: begin
                if (dec_funct == core_pkg::LUI_FUNCT) begin
                    kind     = core_pkg::KIND_WB;
                    ex_value = {dec_imm[15:0], 16'h0000};
                end
            end
            core_pkg::OP_BRANCH: begin
                kind     = core_pkg::KIND_BRANCH;
                ex_value = {31'b0, taken};
                out_pc   = br_target;
            end
            core_pkg::OP_JUMP: begin
                kind   = core_pkg::KIND_JUMP;
                out_pc = dec_jaddr;
            end
            default: kind = core_pkg::KIND_ILLEGAL;  // ops 001, 010, 011
        endcase
    end

    // seen by decode as the first forwarding source
    assign ex_wen = dec_valid && dec_wen;
    assign ex_rd  = dec_rd;

    always_ff @(posedge clk) begin
        if (advance) begin
            exr_kind  <= kind;
            exr_rd    <= dec_rd;
            exr_value <= ex_value;
            exr_pc    <= out_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exr_valid <= 1'b0;
            exr_wen   <= 1'b0;
        end else if (advance) begin
            exr_valid <= dec_valid;
            exr_wen   <= ex_wen;
        end
    end

endmodule

// File: src/decode.sv
`timescale 1ns/10ps

module decode (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 advance,
    input  logic                 q_valid,
    input  core_pkg::inst_t      q_inst,
    input  core_pkg::pc_t        q_pc,
    input  core_pkg::word_t      rd1,
    input  core_pkg::word_t      rd2,
    input  logic                 ex_wen,
    input  core_pkg::reg_idx_t   ex_rd,
    input  core_pkg::word_t      ex_value,
    input  logic                 res_wen,
    input  core_pkg::reg_idx_t   res_rd,
    input  core_pkg::word_t      res_value,
    output logic                 pop,
    output core_pkg::reg_idx_t   rs1,
    output core_pkg::reg_idx_t   rs2,
    output logic                 dec_valid,
    output core_pkg::op_e        dec_op,
    output logic [2:0]           dec_funct,
    output core_pkg::word_t      dec_a,
    output core_pkg::word_t      dec_b,
    output core_pkg::word_t      dec_imm,
    output core_pkg::reg_idx_t   dec_rd,
    output logic                 dec_wen,
    output core_pkg::pc_t        dec_pc,
    output core_pkg::pc_t        dec_jaddr
);

    logic [2:0]          op;
    logic [2:0]          funct;
    core_pkg::reg_idx_t  rd;
    core_pkg::word_t     imm_il;
    core_pkg::word_t     imm_sb;
    core_pkg::word_t     fwd_a;
    core_pkg::word_t     fwd_b;
    logic                writes_rd;

    assign op    = q_inst[2:0];
    assign funct = q_inst[5:3];
    assign rs1   = q_inst[31:27];
    assign rs2   = q_inst[10:6];
    assign rd    = q_inst[26:22];

    assign imm_il = {{16{q_inst[21]}}, q_inst[21:6]};   // I and L forms
    assign imm_sb = {{16{q_inst[26]}}, q_inst[26:11]};  // S and B forms

    assign pop = advance && q_valid;

    // instruction in execute wins over the one in result
    function automatic core_pkg::word_t forward(input core_pkg::reg_idx_t idx,
                                                input core_pkg::word_t    rf_data);
        if (idx == '0)
            return rf_data;
        else if (ex_wen && ex_rd == idx)
            return ex_value;
        else if (res_wen && res_rd == idx)
            return res_value;
        else
            return rf_data;
    endfunction

    assign fwd_a = forward(rs1, rd1);
    assign fwd_b = forward(rs2, rd2);

    always_comb begin
        writes_rd = 1'b0;
        case (op)
            core_pkg::OP_ALU,
            core_pkg::OP_ALUI:  writes_rd = 1'b1;
            core_pkg::OP_UPPER: writes_rd = (funct == core_pkg::LUI_FUNCT);
            default:            writes_rd = 1'b0;  // branch, jump, illegal
        endcase
    end

    // payload has no reset
    always_ff @(posedge clk) begin
        if (advance) begin
            dec_op    <= core_pkg::op_e'(op);
            dec_funct <= funct;
            dec_a     <= fwd_a;
            dec_b     <= (op == core_pkg::OP_ALUI || op == core_pkg::OP_UPPER) ? imm_il : fwd_b;
            dec_imm   <= (op == core_pkg::OP_BRANCH) ? imm_sb : imm_il;
            dec_rd    <= rd;
            dec_pc    <= q_pc;
            dec_jaddr <= {q_inst[30:6], 2'b00};  // word address to byte pc
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
            dec_wen   <= 1'b0;
        end else if (advance) begin
            dec_valid <= q_valid;  // bubble when the queue is empty
            dec_wen   <= q_valid && writes_rd && rd != '0;
        end
    end

endmodule

// File: src/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                 clk,
    input  logic                 reset,
    input  core_pkg::reg_idx_t   rs1,
    input  core_pkg::reg_idx_t   rs2,
    input  logic                 wen,
    input  core_pkg::reg_idx_t   wd_idx,
    input  core_pkg::word_t      wd,
    output core_pkg::word_t      rd1,
    output core_pkg::word_t      rd2
);

    core_pkg::word_t regs [31:1];  // r0 has no storage

    function automatic core_pkg::word_t read_port(input core_pkg::reg_idx_t idx);
        if (idx == '0)
            return '0;
        else if (wen && wd_idx == idx)
            return wd;  // write of this cycle seen at once
        else
            return regs[idx];
    endfunction

    assign rd1 = read_port(rs1);
    assign rd2 = read_port(rs2);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wen && wd_idx != '0) begin
            regs[wd_idx] <= wd;
        end
    end

endmodule

// File: src/inst_queue.sv
`timescale 1ns/10ps

module inst_queue (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  core_pkg::inst_t  in_inst,
    input  core_pkg::pc_t    in_pc,
    input  logic             pop,
    output logic             in_credit,
    output logic             q_valid,
    output core_pkg::inst_t  q_inst,
    output core_pkg::pc_t    q_pc
);

    core_pkg::inst_t inst_mem [core_pkg::QUEUE_DEPTH];
    core_pkg::pc_t   pc_mem   [core_pkg::QUEUE_DEPTH];

    logic [core_pkg::QPTR_W-1:0] wr_ptr;
    logic [core_pkg::QPTR_W-1:0] rd_ptr;
    logic [core_pkg::QCNT_W-1:0] q_cnt;

    assign q_valid = (q_cnt != '0);
    assign q_inst  = inst_mem[rd_ptr];  // head goes straight to decode
    assign q_pc    = pc_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (in_valid) begin
            inst_mem[wr_ptr] <= in_inst;
            pc_mem[wr_ptr]   <= in_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_cnt     <= '0;
            in_credit <= 1'b0;
        end else begin
            in_credit <= pop;  // one credit back per entry taken
            if (in_valid)
                wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({in_valid, pop})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

    // the sender only pushes against credits it holds
    a_no_push_full: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> (q_cnt != core_pkg::QUEUE_DEPTH));

    // decode only pops a valid head
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> q_valid);

endmodule

// File: src/core_pkg.sv
package core_pkg;

    // data widths
    typedef logic [31:0] word_t;     // register and ALU data
    typedef logic [31:0] inst_t;     // instruction word
    typedef logic [26:0] pc_t;       // byte pc
    typedef logic [4:0]  reg_idx_t;  // register index

    // major opcode in inst[2:0]
    typedef enum logic [2:0] {
        OP_ALU    = 3'b000,  // register-register
        OP_ALUI   = 3'b100,  // register-immediate
        OP_UPPER  = 3'b101,  // only funct 010 (lui) is legal
        OP_BRANCH = 3'b110,
        OP_JUMP   = 3'b111
    } op_e;

    // ALU function in inst[5:3]
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,
        SRL = 3'd6,
        SLT = 3'd7   // signed compare
    } alu_fn_e;

    // branch condition in inst[5:3]
    typedef enum logic [2:0] {
        EQ  = 3'd0,
        NE  = 3'd1,
        LT  = 3'd2,
        GE  = 3'd3,
        LTU = 3'd4,
        GEU = 3'd5
    } br_fn_e;

    // kind of output record
    typedef enum logic [1:0] {
        KIND_WB      = 2'd0,
        KIND_BRANCH  = 2'd1,
        KIND_JUMP    = 2'd2,
        KIND_ILLEGAL = 2'd3
    } kind_e;

    localparam logic [2:0] LUI_FUNCT = 3'b010;  // funct of lui under OP_UPPER

    // input queue, depth must be a power of two
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

    // credits held by the core for the output side
    localparam int OUT_CREDITS = 2;
    localparam int OUT_CNT_W   = $clog2(OUT_CREDITS + 1);

endpackage
